/* include/noc_cfg.svh */
`ifndef NOC_CFG_SVH
`define NOC_CFG_SVH

// Number of tiles in the row, x = 1 to NOC_NUM_TILES.
`define NOC_NUM_TILES 4

// Width of the x coordinate. x = 0 is the host endpoint.
`define NOC_X_W 3

// Word address inside one tile memory.
`define NOC_ADDR_W 4
`define NOC_MEM_WORDS 16

`define NOC_DATA_W 32

// Request tag, echoed back in the response.
`define NOC_TAG_W 4

`endif

/* design/noc_pkg.sv */
`default_nettype none

`include "noc_cfg.svh"

package noc_pkg;

  typedef logic [`NOC_X_W-1:0] noc_x_t;

  typedef enum logic [0:0] {
    e_noc_load  = 1'b0,
    e_noc_store = 1'b1
  } noc_op_e;

  // Request, sent from the host toward a tile.
  typedef struct packed {
    noc_op_e                 op;
    noc_x_t                  dst_x;
    noc_x_t                  src_x;
    logic [`NOC_TAG_W-1:0]   tag;
    logic [`NOC_ADDR_W-1:0]  addr;
    logic [`NOC_DATA_W-1:0]  data;
  } noc_req_pkt_s;

  // Response, sent from the serving tile back to the requester.
  typedef struct packed {
    noc_op_e                 op;
    noc_x_t                  dst_x;
    noc_x_t                  src_x;
    logic [`NOC_TAG_W-1:0]   tag;
    logic [`NOC_DATA_W-1:0]  data;
  } noc_resp_pkt_s;

endpackage

`default_nettype wire

/* design/noc_link_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One directed link. Both networks flow from the tx end to the rx end.
interface noc_link_if;
  import noc_pkg::*;

  logic          fwd_v;
  noc_req_pkt_s  fwd_data;
  logic          fwd_ready;

  logic          rev_v;
  noc_resp_pkt_s rev_data;
  logic          rev_ready;

  modport tx (
    output fwd_v, fwd_data,
    input  fwd_ready,
    output rev_v, rev_data,
    input  rev_ready
  );

  modport rx (
    input  fwd_v, fwd_data,
    output fwd_ready,
    input  rev_v, rev_data,
    output rev_ready
  );

endinterface

`default_nettype wire

/* design/noc_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     v_i,
  input  payload_t data_i,
  output logic     ready_o,
  output logic     v_o,
  output payload_t data_o,
  input  logic     yumi_i
);

  payload_t   mem [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       push;
  logic       pop;

  // Ready looks only at the count, never at v_i.
  assign ready_o = (count != 2'd2);
  assign v_o     = (count != 2'd0);
  assign data_o  = mem[rd_ptr];

  assign push = v_i && ready_o;
  assign pop  = yumi_i && v_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      if (push && !pop) begin
        count <= count + 2'd1;
      end else if (pop && !push) begin
        count <= count - 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr] <= data_i;
    end
  end

endmodule

`default_nettype wire

/* design/noc_router.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_router #(
  parameter type             pkt_t = noc_pkg::noc_req_pkt_s,
  parameter noc_pkg::noc_x_t my_x  = 1
) (
  input  logic clk_i,
  input  logic rst_i,

  input  logic w_v_i,
  input  pkt_t w_data_i,
  output logic w_ready_o,
  output logic w_v_o,
  output pkt_t w_data_o,
  input  logic w_ready_i,

  input  logic e_v_i,
  input  pkt_t e_data_i,
  output logic e_ready_o,
  output logic e_v_o,
  output pkt_t e_data_o,
  input  logic e_ready_i,

  input  logic p_v_i,
  input  pkt_t p_data_i,
  output logic p_ready_o,
  output logic p_v_o,
  output pkt_t p_data_o,
  input  logic p_ready_i
);

  localparam int dir_w = 0;
  localparam int dir_e = 1;
  localparam int dir_p = 2;

  logic       in_v      [3];
  pkt_t       in_data   [3];
  logic       in_ready  [3];
  logic       head_v    [3];
  pkt_t       head_data [3];
  logic       head_yumi [3];
  logic [1:0] head_dir  [3];
  logic       gnt_v     [3];
  logic [1:0] gnt_idx   [3];
  pkt_t       out_data  [3];
  logic       out_ready [3];
  logic [1:0] rr_q      [3];

  assign in_v[dir_w]    = w_v_i;
  assign in_data[dir_w] = w_data_i;
  assign w_ready_o      = in_ready[dir_w];
  assign in_v[dir_e]    = e_v_i;
  assign in_data[dir_e] = e_data_i;
  assign e_ready_o      = in_ready[dir_e];
  assign in_v[dir_p]    = p_v_i;
  assign in_data[dir_p] = p_data_i;
  assign p_ready_o      = in_ready[dir_p];

  assign w_v_o = gnt_v[dir_w];
  assign e_v_o = gnt_v[dir_e];
  assign p_v_o = gnt_v[dir_p];
  assign w_data_o = out_data[dir_w];
  assign e_data_o = out_data[dir_e];
  assign p_data_o = out_data[dir_p];
  assign out_ready[dir_w] = w_ready_i;
  assign out_ready[dir_e] = e_ready_i;
  assign out_ready[dir_p] = p_ready_i;

  for (genvar i = 0; i < 3; i++) begin : g_in
    noc_fifo #(
      .payload_t(pkt_t)
    ) u_fifo (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .v_i    (in_v[i]),
      .data_i (in_data[i]),
      .ready_o(in_ready[i]),
      .v_o    (head_v[i]),
      .data_o (head_data[i]),
      .yumi_i (head_yumi[i])
    );

    // Compare the head's destination with this tile's coordinate.
    assign head_dir[i] = (head_data[i].dst_x > my_x) ? 2'(dir_e) :
                         (head_data[i].dst_x < my_x) ? 2'(dir_w) : 2'(dir_p);
  end

  // Each output scans the inputs starting from its rotating priority pointer.
  always_comb begin
    int idx;
    for (int o = 0; o < 3; o++) begin
      gnt_v[o]   = 1'b0;
      gnt_idx[o] = rr_q[o];
      for (int k = 0; k < 3; k++) begin
        idx = (int'(rr_q[o]) + k) % 3;
        if (!gnt_v[o] && head_v[idx] && (head_dir[idx] == 2'(o))) begin
          gnt_v[o]   = 1'b1;
          gnt_idx[o] = 2'(idx);
        end
      end
      out_data[o] = head_data[gnt_idx[o]];
    end

    // A head pops when the output it won takes it.
    for (int i = 0; i < 3; i++) begin
      head_yumi[i] = 1'b0;
      for (int o = 0; o < 3; o++) begin
        if (gnt_v[o] && (gnt_idx[o] == 2'(i)) && out_ready[o]) begin
          head_yumi[i] = 1'b1;
        end
      end
    end
  end

  // The winner drops to lowest priority after a transfer.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int o = 0; o < 3; o++) begin
        rr_q[o] <= 2'd0;
      end
    end else begin
      for (int o = 0; o < 3; o++) begin
        if (gnt_v[o] && out_ready[o]) begin
          rr_q[o] <= (gnt_idx[o] == 2'd2) ? 2'd0 : gnt_idx[o] + 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* design/tile_mem_endpoint.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_cfg.svh"

module tile_mem_endpoint #(
  parameter noc_pkg::noc_x_t my_x = 1
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   req_v_i,
  input  noc_pkg::noc_req_pkt_s  req_pkt_i,
  output logic                   req_ready_o,
  output logic                   resp_v_o,
  output noc_pkg::noc_resp_pkt_s resp_pkt_o,
  input  logic                   resp_ready_i
);
  import noc_pkg::*;

  logic [`NOC_DATA_W-1:0] mem [`NOC_MEM_WORDS];
  logic                   resp_v_q;
  noc_resp_pkt_s          resp_q;
  logic                   req_fire;

  // One request at a time. A new one waits until the response is taken.
  assign req_ready_o = !resp_v_q;
  assign req_fire    = req_v_i && req_ready_o;

  assign resp_v_o   = resp_v_q;
  assign resp_pkt_o = resp_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_v_q <= 1'b0;
    end else if (req_fire) begin
      resp_v_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_v_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      resp_q.op    <= req_pkt_i.op;
      resp_q.dst_x <= req_pkt_i.src_x;
      resp_q.src_x <= my_x;
      resp_q.tag   <= req_pkt_i.tag;
      if (req_pkt_i.op == e_noc_store) begin
        mem[req_pkt_i.addr] <= req_pkt_i.data;
        resp_q.data         <= req_pkt_i.data;
      end else begin
        resp_q.data <= mem[req_pkt_i.addr];
      end
    end
  end

endmodule

`default_nettype wire

/* design/noc_tile.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_tile #(
  parameter noc_pkg::noc_x_t my_x = 1
) (
  input  logic    clk_i,
  input  logic    rst_i,
  noc_link_if.rx  w_in,
  noc_link_if.tx  w_out,
  noc_link_if.rx  e_in,
  noc_link_if.tx  e_out
);
  import noc_pkg::*;

  logic          ep_req_v;
  noc_req_pkt_s  ep_req_pkt;
  logic          ep_req_ready;
  logic          ep_resp_v;
  noc_resp_pkt_s ep_resp_pkt;
  logic          ep_resp_ready;

  // Requests only ever enter the tile from the network, never from the endpoint.
  noc_router #(
    .pkt_t(noc_req_pkt_s),
    .my_x (my_x)
  ) u_req_router (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .w_v_i    (w_in.fwd_v),
    .w_data_i (w_in.fwd_data),
    .w_ready_o(w_in.fwd_ready),
    .w_v_o    (w_out.fwd_v),
    .w_data_o (w_out.fwd_data),
    .w_ready_i(w_out.fwd_ready),
    .e_v_i    (e_in.fwd_v),
    .e_data_i (e_in.fwd_data),
    .e_ready_o(e_in.fwd_ready),
    .e_v_o    (e_out.fwd_v),
    .e_data_o (e_out.fwd_data),
    .e_ready_i(e_out.fwd_ready),
    .p_v_i    (1'b0),
    .p_data_i ('0),
    .p_ready_o(),
    .p_v_o    (ep_req_v),
    .p_data_o (ep_req_pkt),
    .p_ready_i(ep_req_ready)
  );

  tile_mem_endpoint #(
    .my_x(my_x)
  ) u_endpoint (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_v_i     (ep_req_v),
    .req_pkt_i   (ep_req_pkt),
    .req_ready_o (ep_req_ready),
    .resp_v_o    (ep_resp_v),
    .resp_pkt_o  (ep_resp_pkt),
    .resp_ready_i(ep_resp_ready)
  );

  // Responses target x = 0, so none is ever delivered to the local output.
  noc_router #(
    .pkt_t(noc_resp_pkt_s),
    .my_x (my_x)
  ) u_resp_router (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .w_v_i    (w_in.rev_v),
    .w_data_i (w_in.rev_data),
    .w_ready_o(w_in.rev_ready),
    .w_v_o    (w_out.rev_v),
    .w_data_o (w_out.rev_data),
    .w_ready_i(w_out.rev_ready),
    .e_v_i    (e_in.rev_v),
    .e_data_i (e_in.rev_data),
    .e_ready_o(e_in.rev_ready),
    .e_v_o    (e_out.rev_v),
    .e_data_o (e_out.rev_data),
    .e_ready_i(e_out.rev_ready),
    .p_v_i    (ep_resp_v),
    .p_data_i (ep_resp_pkt),
    .p_ready_o(ep_resp_ready),
    .p_v_o    (),
    .p_data_o (),
    .p_ready_i(1'b0)
  );

endmodule

`default_nettype wire

/* design/noc_row.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_cfg.svh"

module noc_row (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   req_v_i,
  input  noc_pkg::noc_req_pkt_s  req_pkt_i,
  output logic                   req_ready_o,
  output logic                   resp_v_o,
  output noc_pkg::noc_resp_pkt_s resp_pkt_o,
  input  logic                   resp_ready_i
);
  import noc_pkg::*;

  // Boundary b sits between tile b and tile b+1. Boundary 0 is the host side
  // and boundary NOC_NUM_TILES is the open east edge.
  noc_link_if east_link [`NOC_NUM_TILES+1] ();
  noc_link_if west_link [`NOC_NUM_TILES+1] ();

  // Host drives requests eastward into tile 1.
  assign east_link[0].fwd_v    = req_v_i;
  assign east_link[0].fwd_data = req_pkt_i;
  assign req_ready_o           = east_link[0].fwd_ready;
  assign east_link[0].rev_v    = 1'b0;
  assign east_link[0].rev_data = '0;

  // Responses leave tile 1 westward to the host.
  assign resp_v_o              = west_link[0].rev_v;
  assign resp_pkt_o            = west_link[0].rev_data;
  assign west_link[0].rev_ready = resp_ready_i;
  assign west_link[0].fwd_ready = 1'b1;

  // Nothing arrives from beyond the last tile, and anything sent there is taken.
  assign west_link[`NOC_NUM_TILES].fwd_v     = 1'b0;
  assign west_link[`NOC_NUM_TILES].fwd_data  = '0;
  assign west_link[`NOC_NUM_TILES].rev_v     = 1'b0;
  assign west_link[`NOC_NUM_TILES].rev_data  = '0;
  assign east_link[`NOC_NUM_TILES].fwd_ready = 1'b1;
  assign east_link[`NOC_NUM_TILES].rev_ready = 1'b1;

  for (genvar i = 1; i <= `NOC_NUM_TILES; i++) begin : g_tile
    noc_tile #(
      .my_x(noc_x_t'(i))
    ) u_tile (
      .clk_i(clk_i),
      .rst_i(rst_i),
      .w_in (east_link[i-1]),
      .w_out(west_link[i-1]),
      .e_in (west_link[i]),
      .e_out(east_link[i])
    );
  end

endmodule

`default_nettype wire

/* bench/noc_row_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_cfg.svh"

module noc_row_tb;
  import noc_pkg::*;

  localparam int num_fill   = 2 * `NOC_NUM_TILES * `NOC_MEM_WORDS;
  localparam int num_random = 400;
  localparam int num_stall  = 200;
  localparam int num_reqs   = num_fill + num_random + num_stall + 64;
  localparam int cycle_limit = 200 * num_reqs + 2000;

  logic          clk_i;
  logic          rst_i;
  logic          req_v_i;
  noc_req_pkt_s  req_pkt_i;
  logic          req_ready_o;
  logic          resp_v_o;
  noc_resp_pkt_s resp_pkt_o;
  logic          resp_ready_i;

  logic [31:0]            rng;
  logic [31:0]            stall_rng;
  logic [1:0]             resp_mode;
  logic [`NOC_TAG_W-1:0]  tag_ctr;
  int                     cycles;
  logic [`NOC_DATA_W-1:0] model_mem [`NOC_NUM_TILES+1][`NOC_MEM_WORDS];
  noc_resp_pkt_s          exp_q [$];

  noc_row u_dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_v_i     (req_v_i),
    .req_pkt_i   (req_pkt_i),
    .req_ready_o (req_ready_o),
    .resp_v_o    (resp_v_o),
    .resp_pkt_o  (resp_pkt_o),
    .resp_ready_i(resp_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] t;
    t = s ^ (s << 13);
    t = t ^ (t >> 17);
    t = t ^ (t << 5);
    return t;
  endfunction

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input logic [63:0] got, input logic [63:0] want,
                             input string what);
    if (got !== want) begin
      $display("** Error at %0t ns: %s: got %0h, expected %0h", $time, what, got, want);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic noc_req_pkt_s make_req(input logic is_store, input int x,
                                            input int addr, input logic [31:0] data);
    noc_req_pkt_s p;
    p.op    = is_store ? e_noc_store : e_noc_load;
    p.dst_x = noc_x_t'(x);
    p.src_x = '0;
    p.tag   = tag_ctr;
    p.addr  = addr[`NOC_ADDR_W-1:0];
    p.data  = data;
    tag_ctr = tag_ctr + 1'b1;
    return p;
  endfunction

  function automatic noc_req_pkt_s rand_req();
    logic [31:0] r;
    rng = xorshift(rng);
    r   = rng;
    rng = xorshift(rng);
    return make_req(r[0], 1 + int'(r[15:8]) % `NOC_NUM_TILES, int'(r[23:16]), rng);
  endfunction

  // Called on a falling edge. Ready seen here holds until the next rising edge.
  task automatic send_req(input noc_req_pkt_s pkt);
    req_pkt_i = pkt;
    req_v_i   = 1'b1;
    while (!req_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    req_v_i = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(negedge clk_i);
  endtask

  // With nothing outstanding, a duplicated response would show up here.
  task automatic expect_no_response(input string what);
    repeat (10) begin
      @(negedge clk_i);
      check_value(resp_v_o, 1'b0, what);
    end
  endtask

  // Mode 0 always ready, mode 1 ready on about 70 percent of cycles, mode 2 stalled.
  always @(negedge clk_i) begin
    if (resp_mode == 2'd1) begin
      stall_rng    = xorshift(stall_rng);
      resp_ready_i = (stall_rng % 100) >= 30;
    end else begin
      resp_ready_i = (resp_mode == 2'd0);
    end
  end

  always @(posedge clk_i) begin : model
    noc_resp_pkt_s want;
    int            found;
    if (!rst_i && req_v_i && req_ready_o) begin
      want.op    = req_pkt_i.op;
      want.dst_x = req_pkt_i.src_x;
      want.src_x = req_pkt_i.dst_x;
      want.tag   = req_pkt_i.tag;
      if (req_pkt_i.op == e_noc_store) begin
        model_mem[req_pkt_i.dst_x][req_pkt_i.addr] = req_pkt_i.data;
        want.data = req_pkt_i.data;
      end else begin
        want.data = model_mem[req_pkt_i.dst_x][req_pkt_i.addr];
      end
      exp_q.push_back(want);
    end
    if (!rst_i && resp_v_o && resp_ready_i) begin
      // The oldest entry from the same tile must match, which also checks order.
      found = -1;
      for (int i = 0; i < exp_q.size(); i++) begin
        if (found < 0 && exp_q[i].src_x == resp_pkt_o.src_x) begin
          found = i;
        end
      end
      if (found < 0) begin
        abort_run($sformatf("Unexpected response from tile %0d with nothing outstanding",
                            resp_pkt_o.src_x));
      end else begin
        want = exp_q[found];
        check_value(resp_pkt_o.op, want.op, "response op");
        check_value(resp_pkt_o.dst_x, want.dst_x, "response destination x");
        check_value(resp_pkt_o.tag, want.tag, "response tag");
        check_value(resp_pkt_o.data, want.data, "response data");
        exp_q.delete(found);
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      abort_run($sformatf("Timeout after %0d cycles with %0d responses outstanding",
                          cycles, exp_q.size()));
    end
  end

  initial begin
    int low_run;
    rst_i        = 1'b1;
    req_v_i      = 1'b0;
    req_pkt_i    = '0;
    resp_ready_i = 1'b1;
    resp_mode    = 2'd0;
    rng          = 32'hd63c_3951;
    stall_rng    = 32'h0;
    tag_ctr      = '0;
    cycles       = 0;
    repeat (16) @(negedge clk_i);
    rst_i = 1'b0;

    // Idle network after reset.
    repeat (20) begin
      @(negedge clk_i);
      check_value(resp_v_o, 1'b0, "resp_v_o while idle");
      check_value(req_ready_o, 1'b1, "req_ready_o while idle");
    end

    // Fill every word of every tile, then read everything back.
    for (int x = 1; x <= `NOC_NUM_TILES; x++) begin
      for (int a = 0; a < `NOC_MEM_WORDS; a++) begin
        rng = xorshift(rng);
        send_req(make_req(1'b1, x, a, rng));
      end
    end
    for (int x = 1; x <= `NOC_NUM_TILES; x++) begin
      for (int a = 0; a < `NOC_MEM_WORDS; a++) begin
        send_req(make_req(1'b0, x, a, 32'h0));
      end
    end
    wait_drain();

    // Random traffic with occasional idle cycles.
    for (int n = 0; n < num_random; n++) begin
      send_req(rand_req());
      if (rng[31:30] == 2'b00) begin
        @(negedge clk_i);
      end
    end
    wait_drain();

    // Random back-pressure on the response port.
    rng       = xorshift(rng);
    stall_rng <= rng;
    resp_mode <= 2'd1;
    for (int n = 0; n < num_stall; n++) begin
      send_req(rand_req());
    end
    wait_drain();
    resp_mode <= 2'd0;
    expect_no_response("resp_v_o after random stalls");

    // Hold the response port until the request port backs up. A busy endpoint
    // can drop ready for a cycle or two, so wait for a long run of low cycles.
    resp_mode <= 2'd2;
    @(negedge clk_i);
    req_pkt_i = rand_req();
    req_v_i   = 1'b1;
    low_run   = 0;
    while (low_run < 50) begin
      if (req_ready_o) begin
        low_run = 0;
        @(negedge clk_i);
        req_pkt_i = rand_req();
      end else begin
        low_run++;
        @(negedge clk_i);
      end
    end
    resp_mode <= 2'd0;
    while (!req_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    req_v_i = 1'b0;
    wait_drain();
    expect_no_response("resp_v_o after the last response");

    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* noc_row.f */
+incdir+include
design/noc_pkg.sv
design/noc_link_if.sv
design/noc_fifo.sv
design/noc_router.sv
design/tile_mem_endpoint.sv
design/noc_tile.sv
design/noc_row.sv
bench/noc_row_tb.sv
